// ==== source/rv_pkg.sv ====
// shared types, opcodes and stage payloads of the rv32i pipeline, compiled ahead of the RTL
package rv_pkg;

	typedef logic [31:0] data_t;
	typedef logic [4:0] r_t;

	typedef struct packed {
		logic [6:0] funct7;
		r_t rs2;
		r_t rs1;
		logic [2:0] funct3;
		r_t rd;
		logic [6:0] opcode;
	} instr_t;

	// execute operand and store data source
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_EX_MEM,
		FWD_MEM_WB
	} fwd_sel_t;

	// decode compare source
	typedef enum logic [1:0] {
		BFWD_RF,
		BFWD_EX,
		BFWD_MEM,
		BFWD_WB
	} branch_fwd_t;

	localparam logic [6:0] OP_ALU = 7'b0110011;
	localparam logic [6:0] OP_ALUI = 7'b0010011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;

	// addi x0, x0, 0
	localparam data_t NOP_INSTR = 32'h0000_0013;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	// instr is the last field of every stage payload, so a bubble is NOP_INSTR zero-extended
	typedef struct packed {
		data_t pc;
		data_t pc_p4;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		data_t pc_p4;
		data_t rs1;
		data_t rs2;
		data_t imm;
		instr_t instr;
	} id_ex_t;

	typedef struct packed {
		data_t pc_p4;
		data_t alu_result;
		data_t rs2;
		logic rd_wren;
		instr_t instr;
	} ex_mem_t;

	typedef struct packed {
		data_t pc_p4;
		data_t alu_result;
		data_t mem_data;
		logic rd_wren;
		instr_t instr;
	} mem_wb_t;

	// instruction types that write rd
	function automatic logic writes_rd(instr_t i);
		return i.opcode inside {OP_ALU, OP_ALUI, OP_LUI, OP_LOAD, OP_JAL};
	endfunction

endpackage

// ==== source/pipe_reg.sv ====
// stage register between two pipeline stages, instantiated once per stage payload type
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = rv_pkg::data_t
) (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic en,
	input payload_t d,
	output payload_t q
);
	import rv_pkg::*;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= payload_t'($bits(payload_t)'(NOP_INSTR));
		end else if (flush) begin
			// bubble, NOP in instr and rd_wren low
			q <= payload_t'($bits(payload_t)'(NOP_INSTR));
		end else if (en) begin
			q <= d;
		end
	end

	// the hazard unit never asks to hold and squash the same stage at once
	a_flush_not_held : assert property (@(posedge clk) disable iff (!arst_n) !(flush && !en));

endmodule

// ==== source/fetch.sv ====
// fetch stage holding the PC and the instruction memory, loaded through its write port in reset
`timescale 1ns/1ps

module fetch (
	input logic clk,
	input logic arst_n,
	input rv_pkg::data_t pc_bj,
	input logic pc_sel,
	input logic stall,
	input logic imem_we,
	input rv_pkg::data_t imem_addr,
	input rv_pkg::data_t imem_wdata,
	output rv_pkg::if_id_t out
);
	import rv_pkg::*;

	data_t pc;
	data_t pc_p4;
	data_t imem [IMEM_WORDS];

	assign pc_p4 = pc + 32'd4;

	// static not-taken, decode redirects on taken branch or jal
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc_sel ? pc_bj : pc_p4;
		end
	end

	// byte address, one word per clock
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
		end
	end

	always_comb begin
		out.pc = pc;
		out.pc_p4 = pc_p4;
		out.instr = instr_t'(imem[pc[IMEM_AW+1:2]]);
	end

	a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// ==== source/decode.sv ====
// decode stage with register file, immediates and early branch/jump resolution
`timescale 1ns/1ps

module decode (
	input logic clk,
	input logic arst_n,
	input rv_pkg::if_id_t in,
	input rv_pkg::data_t wd,
	input rv_pkg::r_t waddr,
	input logic wren,
	input rv_pkg::data_t ex_data,
	input rv_pkg::data_t mem_data,
	input rv_pkg::data_t wb_data,
	input rv_pkg::branch_fwd_t fwd_rs1,
	input rv_pkg::branch_fwd_t fwd_rs2,
	output rv_pkg::data_t pc_bj,
	output logic pc_sel,
	output rv_pkg::id_ex_t out
);
	import rv_pkg::*;

	data_t rf [32];
	data_t raw;
	data_t imm_b;
	data_t imm_j;
	data_t cmp_a;
	data_t cmp_b;
	logic taken;

	// falling-edge write, a read later in the same cycle sees it
	always_ff @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (wren && waddr != '0) begin
			rf[waddr] <= wd;
		end
	end

	always_comb begin
		raw = in.instr;
		imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
		imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
		case (in.instr.opcode)
			OP_ALUI, OP_LOAD: out.imm = {{20{raw[31]}}, raw[31:20]};
			OP_STORE: out.imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
			OP_LUI: out.imm = {raw[31:12], 12'b0};
			OP_BRANCH: out.imm = imm_b;
			OP_JAL: out.imm = imm_j;
			default: out.imm = '0;
		endcase
		out.pc_p4 = in.pc_p4;
		out.rs1 = rf[in.instr.rs1];
		out.rs2 = rf[in.instr.rs2];
		out.instr = in.instr;
	end

	// compare operands, possibly forwarded from later stages
	always_comb begin
		case (fwd_rs1)
			BFWD_EX: cmp_a = ex_data;
			BFWD_MEM: cmp_a = mem_data;
			BFWD_WB: cmp_a = wb_data;
			default: cmp_a = out.rs1;
		endcase
		case (fwd_rs2)
			BFWD_EX: cmp_b = ex_data;
			BFWD_MEM: cmp_b = mem_data;
			BFWD_WB: cmp_b = wb_data;
			default: cmp_b = out.rs2;
		endcase
		// funct3 bit 0 picks bne over beq
		taken = in.instr.funct3[0] ? (cmp_a != cmp_b) : (cmp_a == cmp_b);
		pc_sel = (in.instr.opcode == OP_BRANCH && taken) || in.instr.opcode == OP_JAL;
		pc_bj = in.pc + ((in.instr.opcode == OP_JAL) ? imm_j : imm_b);
	end

endmodule

// ==== source/execute.sv ====
// execute stage with operand forwarding and the ALU
`timescale 1ns/1ps

module execute (
	input rv_pkg::id_ex_t in,
	input rv_pkg::fwd_sel_t fwd_a,
	input rv_pkg::fwd_sel_t fwd_b,
	input rv_pkg::data_t ex_ex_fwd_data,
	input rv_pkg::data_t mem_ex_fwd_data,
	output rv_pkg::ex_mem_t out
);
	import rv_pkg::*;

	data_t op_a;
	data_t rs2_fwd;
	data_t op_b;
	data_t alu;

	always_comb begin
		case (fwd_a)
			FWD_EX_MEM: op_a = ex_ex_fwd_data;
			FWD_MEM_WB: op_a = mem_ex_fwd_data;
			default: op_a = in.rs1;
		endcase
		case (fwd_b)
			FWD_EX_MEM: rs2_fwd = ex_ex_fwd_data;
			FWD_MEM_WB: rs2_fwd = mem_ex_fwd_data;
			default: rs2_fwd = in.rs2;
		endcase
		op_b = (in.instr.opcode == OP_ALU) ? rs2_fwd : in.imm;
	end

	always_comb begin
		case (in.instr.funct3)
			3'b000: begin
				// sub only for register form
				if (in.instr.opcode == OP_ALU && in.instr.funct7[5]) begin
					alu = op_a - op_b;
				end else begin
					alu = op_a + op_b;
				end
			end
			3'b010: alu = {31'b0, $signed(op_a) < $signed(op_b)};
			3'b100: alu = op_a ^ op_b;
			3'b110: alu = op_a | op_b;
			3'b111: alu = op_a & op_b;
			default: alu = op_a + op_b;
		endcase
		case (in.instr.opcode)
			OP_LOAD, OP_STORE: out.alu_result = op_a + op_b;
			OP_LUI: out.alu_result = in.imm;
			// link value, so later stages can forward it like any result
			OP_JAL: out.alu_result = in.pc_p4;
			default: out.alu_result = alu;
		endcase
		out.pc_p4 = in.pc_p4;
		out.rs2 = rs2_fwd;
		out.rd_wren = writes_rd(in.instr);
		out.instr = in.instr;
	end

endmodule

// ==== source/memory.sv ====
// data memory, read with the execute-stage address so the word is ready in the memory stage
`timescale 1ns/1ps

module memory (
	input logic clk,
	input rv_pkg::data_t addr,
	input rv_pkg::ex_mem_t in,
	input logic store_x,
	input rv_pkg::data_t mem_mem_fwd_data,
	input rv_pkg::fwd_sel_t fwd_m2m,
	output rv_pkg::data_t data_out
);
	import rv_pkg::*;

	data_t dmem [DMEM_WORDS];
	data_t store_data;

	// a load one slot ahead hands over its word as it leaves for write-back
	assign store_data = (fwd_m2m == FWD_NONE) ? in.rs2 : mem_mem_fwd_data;

	// store commits at the end of execute, so a following load reads it
	always_ff @(posedge clk) begin
		if (store_x) begin
			dmem[addr[DMEM_AW+1:2]] <= store_data;
		end
		data_out <= dmem[addr[DMEM_AW+1:2]];
	end

endmodule

// ==== source/hazard_ctrl.sv ====
// hazard unit, produces forwarding selects, stalls and flushes for the stage registers
`timescale 1ns/1ps

module hazard_ctrl (
	input rv_pkg::instr_t instr_d,
	input rv_pkg::instr_t instr_x,
	input rv_pkg::instr_t instr_m,
	input rv_pkg::instr_t instr_w,
	input logic ex_mem_wr_rd,
	input logic mem_wb_wr_rd,
	input logic pc_sel,
	output rv_pkg::fwd_sel_t fwd_a,
	output rv_pkg::fwd_sel_t fwd_b,
	output rv_pkg::fwd_sel_t fwd_m2m,
	output rv_pkg::branch_fwd_t fwd_rs1,
	output rv_pkg::branch_fwd_t fwd_rs2,
	output logic stall_if_id,
	output logic stall_id_ex,
	output logic flush_if_id,
	output logic flush_id_ex
);
	import rv_pkg::*;

	logic x_wr;
	logic m_wr;
	logic w_wr;
	logic rs1_used;
	logic rs2_used;
	logic load_use;
	logic branch_wait;

	// youngest producer wins
	function automatic fwd_sel_t ex_src(r_t rs);
		if (m_wr && instr_m.rd == rs) return FWD_EX_MEM;
		if (w_wr && instr_w.rd == rs) return FWD_MEM_WB;
		return FWD_NONE;
	endfunction

	function automatic branch_fwd_t br_src(r_t rs);
		if (x_wr && instr_x.rd == rs) return BFWD_EX;
		if (m_wr && instr_m.rd == rs) return BFWD_MEM;
		if (w_wr && instr_w.rd == rs) return BFWD_WB;
		return BFWD_RF;
	endfunction

	always_comb begin
		x_wr = writes_rd(instr_x) && instr_x.rd != '0;
		m_wr = ex_mem_wr_rd && instr_m.rd != '0;
		w_wr = mem_wb_wr_rd && instr_w.rd != '0;
		rs1_used = instr_d.opcode inside {OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH};
		// store data is exempt, memory-to-memory forwarding covers it
		rs2_used = instr_d.opcode inside {OP_ALU, OP_BRANCH};
		load_use = x_wr && instr_x.opcode == OP_LOAD &&
			((rs1_used && instr_d.rs1 == instr_x.rd) || (rs2_used && instr_d.rs2 == instr_x.rd));
		// branch needs the loaded word in write-back before it can compare
		branch_wait = instr_d.opcode == OP_BRANCH && m_wr && instr_m.opcode == OP_LOAD &&
			(instr_d.rs1 == instr_m.rd || instr_d.rs2 == instr_m.rd);

		fwd_a = ex_src(instr_x.rs1);
		fwd_b = ex_src(instr_x.rs2);
		fwd_rs1 = br_src(instr_d.rs1);
		fwd_rs2 = br_src(instr_d.rs2);
		fwd_m2m = (instr_x.opcode == OP_STORE && m_wr && instr_m.opcode == OP_LOAD &&
			instr_m.rd == instr_x.rs2) ? FWD_EX_MEM : FWD_NONE;

		stall_if_id = load_use || branch_wait;
		// ID/EX takes a bubble on a stall rather than holding
		stall_id_ex = 1'b0;
		flush_id_ex = stall_if_id;
		flush_if_id = pc_sel && !stall_if_id;
	end

endmodule

// ==== source/proc.sv ====
// processor top level, wires the five stages and reports each register write-back
`timescale 1ns/1ps

module proc (
	input logic clk,
	input logic arst_n,
	input logic imem_we,
	input rv_pkg::data_t imem_addr,
	input rv_pkg::data_t imem_wdata,
	output logic wb_valid,
	output rv_pkg::r_t wb_rd,
	output rv_pkg::data_t wb_value
);
	import rv_pkg::*;

	if_id_t if_f, if_d;
	id_ex_t id_d, id_x;
	ex_mem_t ex_x, ex_m;
	mem_wb_t mem_m, mem_w;
	data_t mem_data_m;
	data_t wb_data;
	data_t pc_bj;
	logic pc_sel;
	logic store_x;
	fwd_sel_t fwd_a, fwd_b, fwd_m2m;
	branch_fwd_t fwd_rs1, fwd_rs2;
	logic stall_if_id, stall_id_ex, flush_if_id, flush_id_ex;

	fetch fetch_inst (
		.clk(clk), .arst_n(arst_n), .pc_bj(pc_bj), .pc_sel(pc_sel), .stall(stall_if_id),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata), .out(if_f)
	);
	pipe_reg #(.payload_t(if_id_t)) if_id_reg (
		.clk(clk), .arst_n(arst_n), .flush(flush_if_id), .en(!stall_if_id), .d(if_f), .q(if_d)
	);

	decode decode_inst (
		.clk(clk), .arst_n(arst_n), .in(if_d),
		.wd(wb_data), .waddr(mem_w.instr.rd), .wren(mem_w.rd_wren),
		.ex_data(ex_x.alu_result), .mem_data(ex_m.alu_result), .wb_data(wb_data),
		.fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .pc_bj(pc_bj), .pc_sel(pc_sel), .out(id_d)
	);
	pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
		.clk(clk), .arst_n(arst_n), .flush(flush_id_ex), .en(!stall_id_ex), .d(id_d), .q(id_x)
	);

	execute execute_inst (
		.in(id_x), .fwd_a(fwd_a), .fwd_b(fwd_b), .ex_ex_fwd_data(ex_m.alu_result),
		.mem_ex_fwd_data(wb_data), .out(ex_x)
	);
	// later stages never stall
	pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
		.clk(clk), .arst_n(arst_n), .flush(1'b0), .en(1'b1), .d(ex_x), .q(ex_m)
	);

	assign store_x = id_x.instr.opcode == OP_STORE;

	// store data bypass takes the word the memory stage is reading out
	memory memory_inst (
		.clk(clk), .addr(ex_x.alu_result), .in(ex_x), .store_x(store_x),
		.mem_mem_fwd_data(mem_data_m), .fwd_m2m(fwd_m2m), .data_out(mem_data_m)
	);

	assign mem_m = '{pc_p4: ex_m.pc_p4, alu_result: ex_m.alu_result, mem_data: mem_data_m,
		rd_wren: ex_m.rd_wren, instr: ex_m.instr};

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
		.clk(clk), .arst_n(arst_n), .flush(1'b0), .en(1'b1), .d(mem_m), .q(mem_w)
	);

	hazard_ctrl hazard_ctrl_inst (
		.instr_d(if_d.instr), .instr_x(id_x.instr), .instr_m(ex_m.instr), .instr_w(mem_w.instr),
		.ex_mem_wr_rd(ex_m.rd_wren), .mem_wb_wr_rd(mem_w.rd_wren), .pc_sel(pc_sel),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_m2m(fwd_m2m), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
		.stall_if_id(stall_if_id), .stall_id_ex(stall_id_ex),
		.flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
	);

	// write-back mux and report port
	always_comb begin
		case (mem_w.instr.opcode)
			OP_LOAD: wb_data = mem_w.mem_data;
			OP_JAL: wb_data = mem_w.pc_p4;
			default: wb_data = mem_w.alu_result;
		endcase
		wb_valid = mem_w.rd_wren && mem_w.instr.rd != '0;
		wb_rd = mem_w.instr.rd;
		wb_value = wb_data;
	end

endmodule

// ==== verif/proc_tb.sv ====
// testbench for the pipeline top level, loads the golden program and checks the retirements
`timescale 1ns/1ps

module proc_tb;
	import rv_pkg::*;

	localparam int MIN_RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 20;
	localparam string GOLDEN_FILE = "verif/proc_golden.txt";

	logic clk;
	logic arst_n;
	logic imem_we;
	data_t imem_addr;
	data_t imem_wdata;
	logic wb_valid;
	r_t wb_rd;
	data_t wb_value;

	data_t prog_addr [$];
	data_t prog_word [$];
	data_t exp_rd [$];
	data_t exp_value [$];

	int mismatches;
	int extras;
	int timeouts;
	int file_errors;
	int checked;
	int cycles;
	int limit;

	proc dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_value(wb_value)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	// P lines carry program words, E lines the expected retirements in order
	task automatic read_golden();
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		data_t a;
		data_t b;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("cannot open golden file %s", GOLDEN_FILE);
			file_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%c %h %h", kind, a, b);
			if (n == 3 && kind == "P") begin
				prog_addr.push_back(a);
				prog_word.push_back(b);
			end else if (n == 3 && kind == "E") begin
				exp_rd.push_back(a);
				exp_value.push_back(b);
			end
		end
		$fclose(fd);
		if (prog_word.size() == 0 || exp_rd.size() == 0) begin
			$display("golden file holds no program or no expected trace");
			file_errors++;
		end
	endtask

	// falling edge, well away from the stage register updates
	always @(negedge clk) begin
		if (!arst_n) begin
			check_value("wb_valid in reset", 32'd0, {31'b0, wb_valid});
		end else begin
			if (wb_valid) begin
				if (checked >= exp_rd.size()) begin
					$display("extra retirement of x%0d = %h after the expected trace", wb_rd, wb_value);
					extras++;
				end else begin
					// first instruction fetched in cycle 0 retires in cycle 4
					if (checked == 0) begin
						check_value("first retirement cycle", 32'd4, data_t'(cycles));
					end
					check_value($sformatf("retirement %0d rd", checked), exp_rd[checked],
						{27'b0, wb_rd});
					check_value($sformatf("retirement %0d value", checked), exp_value[checked],
						wb_value);
					checked++;
				end
			end
			cycles++;
		end
	end

	initial begin : main_flow
		int i;
		int reset_len;
		clk = 1'b0;
		arst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		mismatches = 0;
		extras = 0;
		timeouts = 0;
		file_errors = 0;
		checked = 0;
		cycles = 0;
		read_golden();
		limit = 8 * prog_word.size() + 100;

		// reset stays low until the whole program is in
		reset_len = (prog_word.size() > MIN_RESET_CYCLES) ? prog_word.size() : MIN_RESET_CYCLES;
		for (i = 0; i < reset_len; i++) begin
			@(posedge clk);
			if (i < prog_word.size()) begin
				imem_we <= 1'b1;
				imem_addr <= prog_addr[i];
				imem_wdata <= prog_word[i];
			end else begin
				imem_we <= 1'b0;
			end
		end
		@(posedge clk);
		imem_we <= 1'b0;
		arst_n <= 1'b1;

		while (checked < exp_rd.size() && cycles < limit) begin
			@(posedge clk);
		end
		if (checked < exp_rd.size()) begin
			$display("timeout after %0d cycles, trace did not complete (%0d of %0d retirements)",
				cycles, checked, exp_rd.size());
			timeouts++;
		end else begin
			// the self-loop must stay quiet
			repeat (DRAIN_CYCLES) @(posedge clk);
		end

		$display("errors: %0d mismatches, %0d extra retirements, %0d timeouts, %0d file errors",
			mismatches, extras, timeouts, file_errors);
		if (mismatches + extras + timeouts + file_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
source/rv_pkg.sv
source/pipe_reg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/hazard_ctrl.sv
source/proc.sv
verif/proc_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module proc_tb --Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vproc_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verif/proc_golden.txt ====
# P <byte address> <instruction word>, hex, loaded through the imem port in reset
# E <destination register> <write-back value>, hex, in retirement order
P 00 00500093  # addi x1, x0, 5
P 04 12345137  # lui  x2, 0x12345
P 08 00708013  # addi x0, x1, 7 (never reported)
P 0c 401101b3  # sub  x3, x2, x1
P 10 0021c233  # xor  x4, x3, x2
P 14 00402223  # sw   x4, 4(x0)
P 18 00402283  # lw   x5, 4(x0)
P 1c 0050a333  # slt  x6, x1, x5 (load-use)
P 20 00402383  # lw   x7, 4(x0)
P 24 00702423  # sw   x7, 8(x0) (store data from load)
P 28 00802403  # lw   x8, 8(x0)
P 2c 00540463  # beq  x8, x5, +8 (taken, operand from load)
P 30 00100493  # addi x9, x0, 1 (wrong path)
P 34 006274b3  # and  x9, x4, x6
P 38 00149463  # bne  x9, x1, +8 (taken, operand from previous)
P 3c 00200493  # addi x9, x0, 2 (wrong path)
P 40 00248463  # beq  x9, x2, +8 (not taken)
P 44 0024e533  # or   x10, x9, x2
P 48 008005ef  # jal  x11, +8
P 4c 00300613  # addi x12, x0, 3 (jumped over)
P 50 00158633  # add  x12, x11, x1
P 54 0000006f  # jal  x0, 0 (self-loop)
E 01 00000005
E 02 12345000
E 03 12344ffb
E 04 00001ffb
E 05 00001ffb
E 06 00000001
E 07 00001ffb
E 08 00001ffb
E 09 00000001
E 0a 12345001
E 0b 0000004c
E 0c 00000051
